/* build.f */
+incdir+include
verilog/z80_pkg.sv
verilog/datapath_bus_if.sv
verilog/z80_alu.sv
verilog/z80_regfile.sv
verilog/z80_acc_flags.sv
verilog/z80_scratch_regs.sv
verilog/z80_bus_mux.sv
verilog/z80_datapath.sv
bench/tb_z80_datapath.sv

/* Makefile */
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_z80_datapath
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# build, run and look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference state of the datapath, kept next to the DUT
// index 0..9 follows the load mask from its top bit down, b first
z80_pkg::byte_t m_gpr [10];
z80_pkg::byte_t m_shadow [6];
z80_pkg::byte_t m_a;
z80_pkg::byte_t m_f;
z80_pkg::byte_t m_temp;
z80_pkg::byte_t m_mdr;
z80_pkg::word_t m_mar;

function automatic void model_reset();
  foreach (m_gpr[i]) m_gpr[i] = '0;
  foreach (m_shadow[i]) m_shadow[i] = '0;
  m_a    = '0;
  m_f    = '0;
  m_temp = '0;
  m_mdr  = '0;
  m_mar  = '0;
endfunction

// alu result, cut down to 8 bits for the narrow alu
function automatic z80_pkg::word_t alu_model(z80_pkg::word_t a, z80_pkg::byte_t b,
                                             z80_pkg::alu_op_e op, bit wide);
  z80_pkg::word_t y;
  case (op)
    z80_pkg::OP_INCR:     y = a + 16'd1;
    z80_pkg::OP_DECR:     y = a - 16'd1;
    z80_pkg::OP_ADD:      y = a + {8'h00, b};
    z80_pkg::OP_PASS_B:   y = {8'h00, b};
    z80_pkg::OP_ADD_SE_B: y = a + {{8{b[7]}}, b};
    default:              y = a;
  endcase
  return wide ? y : (y & 16'h00ff);
endfunction

// only decr touches a flag, pv tells whether the result is nonzero
function automatic z80_pkg::byte_t alu_flags(z80_pkg::byte_t f, z80_pkg::alu_op_e op,
                                             z80_pkg::word_t y);
  z80_pkg::byte_t r;
  r = f;
  if (op == z80_pkg::OP_DECR) begin
    r[z80_pkg::PV_BIT] = (y != '0);
  end
  return r;
endfunction

function automatic z80_pkg::byte_t force_flag(z80_pkg::byte_t f, int pos,
                                              z80_pkg::flag_force_e ff);
  z80_pkg::byte_t r;
  r = f;
  if (ff == z80_pkg::FF_SET) r[pos] = 1'b1;
  else if (ff == z80_pkg::FF_CLR) r[pos] = 1'b0;
  return r;
endfunction

function automatic z80_pkg::word_t pair_value(z80_pkg::pair_e p);
  return {m_gpr[2*int'(p)], m_gpr[2*int'(p)+1]};
endfunction

// ---------------------------------------------------------------------
// bus predictions from the current command and model state
// ---------------------------------------------------------------------
function automatic z80_pkg::byte_t predict_data();
  z80_pkg::word_t y8;
  y8 = alu_model({8'h00, m_a}, data_in, alu_op, 1'b0);
  case (data_sel)
    z80_pkg::DS_NONE: return data_in;
    z80_pkg::DS_A:    return m_a;
    z80_pkg::DS_F:    return m_f;
    z80_pkg::DS_TEMP: return m_temp;
    z80_pkg::DS_MDR:  return m_mdr;
    z80_pkg::DS_ALU8: return y8[7:0];
    default:          return m_gpr[int'(data_sel) - int'(z80_pkg::DS_B)];
  endcase
endfunction

function automatic z80_pkg::word_t predict_addr();
  case (addr_sel)
    z80_pkg::AS_MAR:   return m_mar;
    z80_pkg::AS_ALU16: return alu_model(pair_value(pair_sel), m_temp, alu_op, 1'b1);
    default:           return '0;
  endcase
endfunction

// ---------------------------------------------------------------------
// state update at the clock edge
// ---------------------------------------------------------------------
function automatic void model_step();
  z80_pkg::byte_t d;
  z80_pkg::word_t ad;
  z80_pkg::byte_t f_new;
  z80_pkg::byte_t g [10];
  bit             f_wr;
  d  = predict_data();
  ad = predict_addr();
  g  = m_gpr;
  if (exx) begin
    // masked b..l trade with their shadows, sp and pc hold
    for (int i = 0; i < 6; i++) begin
      if (reg_ld[9-i]) begin
        g[i]        = m_shadow[i];
        m_shadow[i] = m_gpr[i];
      end
    end
  end else begin
    // i^1 is the other byte of the same pair
    for (int i = 0; i < 10; i++) begin
      if (reg_ld[9-i] && reg_ld[9-(i^1)]) g[i] = (i % 2 == 0) ? ad[15:8] : ad[7:0];
      else if (reg_ld[9-i]) g[i] = d;
    end
  end
  m_gpr = g;
  f_new = m_f;
  if (ld_f8) begin
    f_new = alu_flags(m_f, alu_op, alu_model({8'h00, m_a}, data_in, alu_op, 1'b0));
  end else if (ld_f16) begin
    f_new = alu_flags(m_f, alu_op, alu_model(pair_value(pair_sel), m_temp, alu_op, 1'b1));
  end
  f_new = force_flag(f_new, z80_pkg::S_BIT, flag_force.s);
  f_new = force_flag(f_new, z80_pkg::Z_BIT, flag_force.z);
  f_new = force_flag(f_new, z80_pkg::H_BIT, flag_force.h);
  f_new = force_flag(f_new, z80_pkg::PV_BIT, flag_force.pv);
  f_new = force_flag(f_new, z80_pkg::N_BIT, flag_force.n);
  f_new = force_flag(f_new, z80_pkg::C_BIT, flag_force.c);
  // any force field away from keep writes f too
  f_wr = ld_f8 || ld_f16 || (flag_force != '0);
  if (f_wr) m_f = f_new;
  if (ld_a) m_a = d;
  if (ld_temp) m_temp = d;
  if (ld_mdr) m_mdr = d;
  if (mar_ld_h) m_mar[15:8] = ad[15:8];
  if (mar_ld_l) m_mar[7:0] = ad[7:0];
endfunction

`endif

/* bench/tb_z80_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

// random command testbench for the z80 datapath
module tb_z80_datapath;

  localparam int n_cmds      = 2000;
  localparam int rst_cycles  = 2;
  localparam int half_period = 50;
  localparam int drive_dly   = 5;
  // commands plus reset and some slack
  localparam int max_cycles  = n_cmds + 100;

  logic                  clk;
  logic                  arst_n;
  z80_pkg::byte_t        data_in;
  z80_pkg::data_src_e    data_sel;
  z80_pkg::addr_src_e    addr_sel;
  z80_pkg::pair_e        pair_sel;
  z80_pkg::reg_ld_t      reg_ld;
  logic                  exx;
  z80_pkg::alu_op_e      alu_op;
  logic                  ld_a;
  logic                  ld_f8;
  logic                  ld_f16;
  z80_pkg::flag_force_t  flag_force;
  logic                  ld_temp;
  logic                  ld_mdr;
  logic                  mar_ld_h;
  logic                  mar_ld_l;
  z80_pkg::byte_t        data_out;
  logic                  data_oe;
  z80_pkg::word_t        addr_out;
  logic                  addr_oe;

  logic [31:0]           rng_state;
  int unsigned           cycle_cnt = 0;
  z80_pkg::reg_ld_t      last_exx_mask;

  `include "tb_model.svh"

  z80_datapath u_dut (
    .clk(clk), .arst_n(arst_n), .data_in(data_in), .data_sel(data_sel),
    .addr_sel(addr_sel), .pair_sel(pair_sel), .reg_ld(reg_ld), .exx(exx),
    .alu_op(alu_op), .ld_a(ld_a), .ld_f8(ld_f8), .ld_f16(ld_f16),
    .flag_force(flag_force), .ld_temp(ld_temp), .ld_mdr(ld_mdr),
    .mar_ld_h(mar_ld_h), .mar_ld_l(mar_ld_l), .data_out(data_out),
    .data_oe(data_oe), .addr_out(addr_out), .addr_oe(addr_oe)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

  // ---------------------------------------------------------------------
  // random numbers and error handling
  // ---------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] rand_u32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic bit rand_bit();
    return (rand_u32() & 32'd1) != 32'd0;
  endfunction

  function automatic z80_pkg::flag_force_e rand_force();
    case (rand_u32() % 32'd3)
      32'd0:   return z80_pkg::FF_KEEP;
      32'd1:   return z80_pkg::FF_CLR;
      default: return z80_pkg::FF_SET;
    endcase
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input z80_pkg::byte_t got,
                            input z80_pkg::byte_t exp);
    if (got !== exp) stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input z80_pkg::word_t got,
                            input z80_pkg::word_t exp);
    if (got !== exp) stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_outputs();
    check_byte("data_out", data_out, predict_data());
    check_bit("data_oe", data_oe, data_sel != z80_pkg::DS_NONE);
    check_word("addr_out", addr_out, predict_addr());
    check_bit("addr_oe", addr_oe, addr_sel != z80_pkg::AS_NONE);
  endtask

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  task automatic drive_idle();
    data_in    = '0;
    data_sel   = z80_pkg::DS_NONE;
    addr_sel   = z80_pkg::AS_NONE;
    pair_sel   = z80_pkg::PR_BC;
    reg_ld     = '0;
    exx        = 1'b0;
    alu_op     = z80_pkg::OP_PASS_A;
    ld_a       = 1'b0;
    ld_f8      = 1'b0;
    ld_f16     = 1'b0;
    flag_force = '0;
    ld_temp    = 1'b0;
    ld_mdr     = 1'b0;
    mar_ld_h   = 1'b0;
    mar_ld_l   = 1'b0;
  endtask

  // one legal command, weighted over the datapath functions
  task automatic make_command();
    int kind;
    int pick;
    drive_idle();
    kind     = int'(rand_u32() % 32'd16);
    pick     = int'(rand_u32() % 32'd13);
    data_in  = z80_pkg::byte_t'(rand_u32());
    pair_sel = z80_pkg::pair_e'(3'(rand_u32() % 32'd5));
    alu_op   = z80_pkg::alu_op_e'(3'(rand_u32()));
    if (kind < 3) begin
      // byte load off data_in into one register
      if (pick < 10) reg_ld = z80_pkg::reg_ld_t'(10'd1 << pick);
      else if (pick == 10) ld_a = 1'b1;
      else if (pick == 11) ld_temp = 1'b1;
      else ld_mdr = 1'b1;
    end else if (kind < 6) begin
      // readback of a through mdr with mar now and then
      data_sel = z80_pkg::data_src_e'(4'(32'd1 + rand_u32() % 32'd14));
      addr_sel = rand_bit() ? z80_pkg::AS_MAR : z80_pkg::AS_NONE;
    end else if (kind < 8) begin
      // whole pair off the address bus
      addr_sel = rand_bit() ? z80_pkg::AS_MAR : z80_pkg::AS_ALU16;
      reg_ld   = z80_pkg::reg_ld_t'(10'b11 << (8 - 2 * (pick % 5)));
    end else if (kind < 11) begin
      data_sel = z80_pkg::DS_ALU8;
      addr_sel = z80_pkg::AS_ALU16;
      ld_f8    = rand_bit();
      ld_f16   = rand_bit();
      ld_a     = rand_bit();
    end else if (kind < 13) begin
      // flag forcing shows on the next f drive
      data_sel      = z80_pkg::DS_F;
      ld_f8         = (rand_u32() % 32'd4) == 32'd0;
      ld_f16        = (rand_u32() % 32'd4) == 32'd0;
      flag_force.s  = rand_force();
      flag_force.z  = rand_force();
      flag_force.h  = rand_force();
      flag_force.pv = rand_force();
      flag_force.n  = rand_force();
      flag_force.c  = rand_force();
    end else if (kind < 14) begin
      // half the exchanges repeat the last mask and undo it
      exx           = 1'b1;
      reg_ld        = rand_bit() ? last_exx_mask : z80_pkg::reg_ld_t'(rand_u32());
      last_exx_mask = reg_ld;
      data_sel      = z80_pkg::data_src_e'(4'(32'd3 + rand_u32() % 32'd6));
    end else begin
      addr_sel = z80_pkg::AS_ALU16;
      mar_ld_h = (pick % 3) != 1;
      mar_ld_l = (pick % 3) != 0;
    end
  endtask

  // cycle limit against a hung run
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      stop_on_error($sformatf("run did not finish within %0d clock cycles", max_cycles));
    end
  end

  initial begin
    rng_state     = 32'd17540;
    last_exx_mask = '0;
    model_reset();
    arst_n = 1'b0;
    drive_idle();
    @(posedge clk);
    // idle selects keep both enables low through reset
    @(negedge clk);
    check_outputs();
    repeat (rst_cycles - 1) @(posedge clk);
    #(drive_dly);
    arst_n = 1'b1;
    for (int n = 0; n < n_cmds; n++) begin
      @(posedge clk);
      model_step();
      #(drive_dly);
      make_command();
      // outputs have settled well before the falling edge
      @(negedge clk);
      check_outputs();
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/z80_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

// 8-bit z80 style datapath top
module z80_datapath (
  input  logic                  clk,
  input  logic                  arst_n,
  input  z80_pkg::byte_t        data_in,
  input  z80_pkg::data_src_e    data_sel,
  input  z80_pkg::addr_src_e    addr_sel,
  input  z80_pkg::pair_e        pair_sel,
  input  z80_pkg::reg_ld_t      reg_ld,
  input  logic                  exx,
  input  z80_pkg::alu_op_e      alu_op,
  input  logic                  ld_a,
  input  logic                  ld_f8,
  input  logic                  ld_f16,
  input  z80_pkg::flag_force_t  flag_force,
  input  logic                  ld_temp,
  input  logic                  ld_mdr,
  input  logic                  mar_ld_h,
  input  logic                  mar_ld_l,
  output z80_pkg::byte_t        data_out,
  output logic                  data_oe,
  output z80_pkg::word_t        addr_out,
  output logic                  addr_oe
);

  // register contents toward the mux and alus
  z80_pkg::byte_t byte_rd;
  z80_pkg::word_t pair_rd;
  z80_pkg::byte_t a_q;
  z80_pkg::byte_t f_q;
  z80_pkg::byte_t alu8_y;
  z80_pkg::word_t alu16_y;
  z80_pkg::byte_t temp_q;
  z80_pkg::byte_t mdr_q;
  z80_pkg::word_t mar_q;

  datapath_bus_if u_bus ();

  z80_regfile u_regfile (
    .clk(clk), .arst_n(arst_n), .reg_ld(reg_ld), .exx(exx), .bus(u_bus.sink),
    .data_sel(data_sel), .pair_sel(pair_sel), .byte_rd(byte_rd), .pair_rd(pair_rd)
  );

  z80_acc_flags u_acc_flags (
    .clk(clk), .arst_n(arst_n), .bus(u_bus.sink), .data_in(data_in),
    .pair_rd(pair_rd), .temp(temp_q), .alu_op(alu_op), .ld_a(ld_a),
    .ld_f8(ld_f8), .ld_f16(ld_f16), .flag_force(flag_force),
    .a_q(a_q), .f_q(f_q), .alu8_y(alu8_y), .alu16_y(alu16_y)
  );

  z80_scratch_regs u_scratch (
    .clk(clk), .arst_n(arst_n), .bus(u_bus.sink), .ld_temp(ld_temp),
    .ld_mdr(ld_mdr), .mar_ld_h(mar_ld_h), .mar_ld_l(mar_ld_l),
    .temp_q(temp_q), .mdr_q(mdr_q), .mar_q(mar_q)
  );

  z80_bus_mux u_bus_mux (
    .data_sel(data_sel), .addr_sel(addr_sel), .data_in(data_in),
    .a_q(a_q), .f_q(f_q), .byte_rd(byte_rd), .temp_q(temp_q), .mdr_q(mdr_q),
    .alu8_y(alu8_y), .mar_q(mar_q), .alu16_y(alu16_y), .bus(u_bus.mux),
    .data_out(data_out), .data_oe(data_oe), .addr_out(addr_out), .addr_oe(addr_oe)
  );

endmodule

`default_nettype wire

/* verilog/z80_bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

// one selected source per internal bus, copied to the external pins
module z80_bus_mux (
  input  z80_pkg::data_src_e  data_sel,
  input  z80_pkg::addr_src_e  addr_sel,
  input  z80_pkg::byte_t      data_in,
  input  z80_pkg::byte_t      a_q,
  input  z80_pkg::byte_t      f_q,
  input  z80_pkg::byte_t      byte_rd,
  input  z80_pkg::byte_t      temp_q,
  input  z80_pkg::byte_t      mdr_q,
  input  z80_pkg::byte_t      alu8_y,
  input  z80_pkg::word_t      mar_q,
  input  z80_pkg::word_t      alu16_y,
  datapath_bus_if.mux         bus,
  output z80_pkg::byte_t      data_out,
  output logic                data_oe,
  output z80_pkg::word_t      addr_out,
  output logic                addr_oe
);

  // ----------------------------------------------------------------------
  // data bus
  // ----------------------------------------------------------------------
  always_comb begin
    bus.data_driven = 1'b1;
    case (data_sel)
      z80_pkg::DS_A:    bus.data_bus = a_q;
      z80_pkg::DS_F:    bus.data_bus = f_q;
      z80_pkg::DS_TEMP: bus.data_bus = temp_q;
      z80_pkg::DS_MDR:  bus.data_bus = mdr_q;
      z80_pkg::DS_ALU8: bus.data_bus = alu8_y;
      z80_pkg::DS_NONE: begin
        // nobody inside drives, the pins feed the bus
        bus.data_bus    = data_in;
        bus.data_driven = 1'b0;
      end
      // b..pcl all come through the regfile read port
      default:          bus.data_bus = byte_rd;
    endcase
  end

  // ----------------------------------------------------------------------
  // address bus, zero when idle
  // ----------------------------------------------------------------------
  always_comb begin
    bus.addr_driven = 1'b1;
    case (addr_sel)
      z80_pkg::AS_MAR:   bus.addr_bus = mar_q;
      z80_pkg::AS_ALU16: bus.addr_bus = alu16_y;
      default: begin
        bus.addr_bus    = '0;
        bus.addr_driven = 1'b0;
      end
    endcase
  end

  // external copies
  assign data_out = bus.data_bus;
  assign data_oe  = bus.data_driven;
  assign addr_out = bus.addr_bus;
  assign addr_oe  = bus.addr_driven;

endmodule

`default_nettype wire

/* verilog/z80_scratch_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// temp and mdr hold bytes off the data bus, mar holds an address
module z80_scratch_regs (
  input  logic            clk,
  input  logic            arst_n,
  datapath_bus_if.sink    bus,
  input  logic            ld_temp,
  input  logic            ld_mdr,
  input  logic            mar_ld_h,
  input  logic            mar_ld_l,
  output z80_pkg::byte_t  temp_q,
  output z80_pkg::byte_t  mdr_q,
  output z80_pkg::word_t  mar_q
);

  localparam int hi = z80_pkg::addr_w - 1;
  localparam int lo = z80_pkg::data_w;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      temp_q <= '0;
      mdr_q  <= '0;
      mar_q  <= '0;
    end else begin
      if (ld_temp) begin
        temp_q <= bus.data_bus;
      end
      if (ld_mdr) begin
        mdr_q <= bus.data_bus;
      end
      // each mar half loads on its own, both together take the word
      if (mar_ld_h) begin
        mar_q[hi:lo] <= bus.addr_bus[hi:lo];
      end
      if (mar_ld_l) begin
        mar_q[lo-1:0] <= bus.addr_bus[lo-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/z80_acc_flags.sv */
`timescale 1ns/1ps
`default_nettype none

// accumulator, flag register and both alus
module z80_acc_flags (
  input  logic                  clk,
  input  logic                  arst_n,
  datapath_bus_if.sink          bus,
  input  z80_pkg::byte_t        data_in,
  input  z80_pkg::word_t        pair_rd,
  input  z80_pkg::byte_t        temp,
  input  z80_pkg::alu_op_e      alu_op,
  input  logic                  ld_a,
  input  logic                  ld_f8,
  input  logic                  ld_f16,
  input  z80_pkg::flag_force_t  flag_force,
  output z80_pkg::byte_t        a_q,
  output z80_pkg::byte_t        f_q,
  output z80_pkg::byte_t        alu8_y,
  output z80_pkg::word_t        alu16_y
);

  z80_pkg::byte_t alu8_f;
  z80_pkg::byte_t alu16_f;
  z80_pkg::byte_t f_next;
  logic           f_en;

  // narrow alu works on a and the external data input
  z80_alu #(.width(z80_pkg::data_w)) u_alu8 (
    .a(a_q), .b(data_in), .op(alu_op), .f_in(f_q), .y(alu8_y), .f_out(alu8_f)
  );

  // wide alu works on a register pair and temp
  z80_alu #(.width(z80_pkg::addr_w)) u_alu16 (
    .a(pair_rd), .b(temp), .op(alu_op), .f_in(f_q), .y(alu16_y), .f_out(alu16_f)
  );

  // set or clear one bit, or leave it for keep
  function automatic logic apply(logic cur, z80_pkg::flag_force_e ff);
    case (ff)
      z80_pkg::FF_SET: return 1'b1;
      z80_pkg::FF_CLR: return 1'b0;
      default:         return cur;
    endcase
  endfunction

  function automatic logic active(z80_pkg::flag_force_e ff);
    return (ff == z80_pkg::FF_SET) || (ff == z80_pkg::FF_CLR);
  endfunction

  // ----------------------------------------------------------------------
  // flag next state
  // ----------------------------------------------------------------------
  always_comb begin
    // 8-bit alu flags win over the wide alu
    f_next = ld_f8 ? alu8_f : (ld_f16 ? alu16_f : f_q);
    f_next[z80_pkg::S_BIT]  = apply(f_next[z80_pkg::S_BIT],  flag_force.s);
    f_next[z80_pkg::Z_BIT]  = apply(f_next[z80_pkg::Z_BIT],  flag_force.z);
    f_next[z80_pkg::H_BIT]  = apply(f_next[z80_pkg::H_BIT],  flag_force.h);
    f_next[z80_pkg::PV_BIT] = apply(f_next[z80_pkg::PV_BIT], flag_force.pv);
    f_next[z80_pkg::N_BIT]  = apply(f_next[z80_pkg::N_BIT],  flag_force.n);
    f_next[z80_pkg::C_BIT]  = apply(f_next[z80_pkg::C_BIT],  flag_force.c);
    // a force alone is enough to write f
    f_en = ld_f8 | ld_f16 | active(flag_force.s) | active(flag_force.z) |
           active(flag_force.h) | active(flag_force.pv) | active(flag_force.n) |
           active(flag_force.c);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
      f_q <= '0;
    end else begin
      if (ld_a) begin
        a_q <= bus.data_bus;
      end
      if (f_en) begin
        f_q <= f_next;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/z80_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

// general registers b..l with shadows, plus sp and pc
// stored as bytes so the data bus can reach each one, pairs are formed
// by concatenation when the address bus is involved
module z80_regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  z80_pkg::reg_ld_t    reg_ld,
  input  logic                exx,
  datapath_bus_if.sink        bus,
  input  z80_pkg::data_src_e  data_sel,
  input  z80_pkg::pair_e      pair_sel,
  output z80_pkg::byte_t      byte_rd,
  output z80_pkg::word_t      pair_rd
);

  // index 0..9 is b, c, d, e, h, l, sph, spl, pch, pcl
  localparam int n_regs  = 10;
  // only b..l have shadow copies
  localparam int n_swap  = 6;
  localparam int n_pairs = n_regs / 2;

  z80_pkg::byte_t gpr_q    [n_regs];
  z80_pkg::byte_t shadow_q [n_swap];

  // ----------------------------------------------------------------------
  // load and exchange
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < n_regs; i++) begin
        gpr_q[i] <= '0;
      end
      for (int i = 0; i < n_swap; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (exx) begin
      // mask picks which of b..l trade places with their shadow
      // sp and pc hold during an exchange
      for (int i = 0; i < n_swap; i++) begin
        if (reg_ld[n_regs-1-i]) begin
          gpr_q[i]    <= shadow_q[i];
          shadow_q[i] <= gpr_q[i];
        end
      end
    end else begin
      for (int p = 0; p < n_pairs; p++) begin
        if (reg_ld[n_regs-1-2*p] && reg_ld[n_regs-2-2*p]) begin
          // whole pair from the address bus, high byte first
          gpr_q[2*p]   <= bus.addr_bus[z80_pkg::addr_w-1:z80_pkg::data_w];
          gpr_q[2*p+1] <= bus.addr_bus[z80_pkg::data_w-1:0];
        end else begin
          // single byte from the data bus
          if (reg_ld[n_regs-1-2*p]) begin
            gpr_q[2*p] <= bus.data_bus;
          end
          if (reg_ld[n_regs-2-2*p]) begin
            gpr_q[2*p+1] <= bus.data_bus;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // read ports
  // ----------------------------------------------------------------------
  // byte read for the data bus, zero when the select is outside the file
  always_comb begin
    case (data_sel)
      z80_pkg::DS_B:   byte_rd = gpr_q[0];
      z80_pkg::DS_C:   byte_rd = gpr_q[1];
      z80_pkg::DS_D:   byte_rd = gpr_q[2];
      z80_pkg::DS_E:   byte_rd = gpr_q[3];
      z80_pkg::DS_H:   byte_rd = gpr_q[4];
      z80_pkg::DS_L:   byte_rd = gpr_q[5];
      z80_pkg::DS_SPH: byte_rd = gpr_q[6];
      z80_pkg::DS_SPL: byte_rd = gpr_q[7];
      z80_pkg::DS_PCH: byte_rd = gpr_q[8];
      z80_pkg::DS_PCL: byte_rd = gpr_q[9];
      default:         byte_rd = '0;
    endcase
  end

  // pair read feeds the wide alu
  always_comb begin
    case (pair_sel)
      z80_pkg::PR_BC: pair_rd = {gpr_q[0], gpr_q[1]};
      z80_pkg::PR_DE: pair_rd = {gpr_q[2], gpr_q[3]};
      z80_pkg::PR_HL: pair_rd = {gpr_q[4], gpr_q[5]};
      z80_pkg::PR_SP: pair_rd = {gpr_q[6], gpr_q[7]};
      z80_pkg::PR_PC: pair_rd = {gpr_q[8], gpr_q[9]};
      default:        pair_rd = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/z80_alu.sv */
`timescale 1ns/1ps
`default_nettype none

// combinational alu, used at 8 bits on a and at 16 bits on a register pair
// b is always a byte, widened to the operand width here
module z80_alu #(
  parameter int width = 8
) (
  input  logic [width-1:0]    a,
  input  z80_pkg::byte_t      b,
  input  z80_pkg::alu_op_e    op,
  input  z80_pkg::byte_t      f_in,
  output logic [width-1:0]    y,
  output z80_pkg::byte_t      f_out
);

  logic [width-1:0] b_zx;
  logic [width-1:0] b_sx;

  // zero extension for add and pass
  assign b_zx = width'(b);
  // sign extension for relative adds
  assign b_sx = width'($signed(b));

  always_comb begin
    // flags pass through unless the op says otherwise
    f_out = f_in;
    case (op)
      z80_pkg::OP_INCR: begin
        y = a + 1'b1;
      end
      z80_pkg::OP_DECR: begin
        y = a - 1'b1;
        // pv marks a nonzero result after the decrement
        f_out[z80_pkg::PV_BIT] = (y != '0);
      end
      z80_pkg::OP_ADD: begin
        y = a + b_zx;
      end
      z80_pkg::OP_PASS_B: begin
        y = b_zx;
      end
      z80_pkg::OP_ADD_SE_B: begin
        // same as add at 8 bits
        y = a + b_sx;
      end
      default: begin
        // pass_a and unused codes
        y = a;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/datapath_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// internal data and address buses of the datapath
// each bus has a single selected source, driven flags say whether
// anything inside the datapath owns it this cycle
interface datapath_bus_if;

  z80_pkg::byte_t data_bus;
  logic           data_driven;
  z80_pkg::word_t addr_bus;
  logic           addr_driven;

  // source selection side
  modport mux (output data_bus, data_driven, addr_bus, addr_driven);

  // register groups that load from the buses
  modport sink (input data_bus, data_driven, addr_bus, addr_driven);

endinterface

`default_nettype wire

/* verilog/z80_pkg.sv */
`default_nettype none

package z80_pkg;

  // datapath widths
  parameter int data_w = 8;
  parameter int addr_w = 16;

  typedef logic [data_w-1:0] byte_t;
  typedef logic [addr_w-1:0] word_t;

  // ----------------------------------------------------------------------
  // alu operations
  // ----------------------------------------------------------------------
  // codes 6 and 7 fall through to pass a
  typedef enum logic [2:0] {
    OP_INCR     = 3'd0,
    OP_DECR     = 3'd1,
    OP_ADD      = 3'd2,
    OP_PASS_B   = 3'd3,
    OP_ADD_SE_B = 3'd4,
    OP_PASS_A   = 3'd5
  } alu_op_e;

  // ----------------------------------------------------------------------
  // bus source selects
  // ----------------------------------------------------------------------
  // ds_none puts data_in on the internal data bus
  typedef enum logic [3:0] {
    DS_NONE, DS_A, DS_F, DS_B, DS_C, DS_D, DS_E, DS_H, DS_L,
    DS_SPH, DS_SPL, DS_PCH, DS_PCL, DS_TEMP, DS_MDR, DS_ALU8
  } data_src_e;

  typedef enum logic [1:0] {AS_NONE, AS_MAR, AS_ALU16} addr_src_e;

  // 16-bit operand of the wide alu
  typedef enum logic [2:0] {PR_BC, PR_DE, PR_HL, PR_SP, PR_PC} pair_e;

  // load mask, bit 9 is b down to bit 0 for pcl
  typedef logic [9:0] reg_ld_t;

  // ----------------------------------------------------------------------
  // flag register layout and forcing
  // ----------------------------------------------------------------------
  parameter int S_BIT  = 7;
  parameter int Z_BIT  = 6;
  parameter int H_BIT  = 4;
  parameter int PV_BIT = 2;
  parameter int N_BIT  = 1;
  parameter int C_BIT  = 0;

  typedef enum logic [1:0] {FF_KEEP = 2'b00, FF_CLR = 2'b10, FF_SET = 2'b11} flag_force_e;

  typedef struct packed {
    flag_force_e s;
    flag_force_e z;
    flag_force_e h;
    flag_force_e pv;
    flag_force_e n;
    flag_force_e c;
  } flag_force_t;

endpackage

`default_nettype wire
